// File: verilog/mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// log2 of the TLB entry count, 16 entries
`define MMU_TLB_INDEX_W 4

// satp MODE field, set selects Sv32
`define MMU_SATP_MODE_BIT 31

// Privileged, secure, data access for page table reads
`define MMU_ARPROT 3'b001

`endif

// File: verilog/sv32_pkg.sv
package sv32_pkg;

  // Sv32 virtual address is vpn[19:0] followed by a 12-bit page offset
  typedef logic [19:0] vpn_t;
  typedef logic [19:0] ppn_t;
  typedef logic [11:0] page_off_t;

  // Port a page table walk is serving
  typedef enum logic {
    REQ_IFU = 1'b0,
    REQ_LSU = 1'b1
  } requester_t;

  // Walker FSM states
  typedef enum logic [1:0] {
    WALK_IDLE = 2'd0,
    WALK_AR   = 2'd1,  // Address phase on AR
    WALK_R    = 2'd2   // Waiting for the PTE on R
  } walk_state_t;

endpackage

// File: verilog/axi_lite_pkg.sv
package axi_lite_pkg;

  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [2:0]  axi_prot_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

endpackage

// File: verilog/sv32_tlb.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

module sv32_tlb (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  input  logic [31:0]          satp,
  input  logic                 ifu_valid,
  input  logic [31:0]          ifu_vaddr,
  input  logic                 lsu_valid,
  input  logic [31:0]          lsu_vaddr,
  input  logic                 fill_valid,
  input  sv32_pkg::requester_t fill_requester,
  input  sv32_pkg::ppn_t       fill_ppn,
  output logic                 ifu_hit,
  output logic [31:0]          ifu_paddr,
  output logic                 lsu_hit,
  output logic [31:0]          lsu_paddr,
  output logic                 ifu_miss,
  output logic                 lsu_miss
);
  import sv32_pkg::*;

  localparam int ENTRIES = 1 << `MMU_TLB_INDEX_W;

  logic                        mode_on;
  vpn_t                        ifu_vpn;
  vpn_t                        lsu_vpn;
  page_off_t                   ifu_off;
  page_off_t                   lsu_off;
  logic [ENTRIES-1:0]          entry_valid;
  vpn_t                        entry_vpn [ENTRIES];
  ppn_t                        entry_ppn [ENTRIES];
  logic [ENTRIES-1:0]          ifu_match;
  logic [ENTRIES-1:0]          lsu_match;
  ppn_t                        ifu_ppn;
  ppn_t                        lsu_ppn;
  logic [`MMU_TLB_INDEX_W-1:0] victim_cnt;
  logic [`MMU_TLB_INDEX_W-1:0] victim;
  vpn_t                        fill_vpn;
  logic                        dup_vpn;

  assign mode_on = satp[`MMU_SATP_MODE_BIT];
  assign ifu_vpn = ifu_vaddr[31:12];
  assign ifu_off = ifu_vaddr[11:0];
  assign lsu_vpn = lsu_vaddr[31:12];
  assign lsu_off = lsu_vaddr[11:0];

  // Both ports searched in parallel, at most one entry can match
  always_comb begin
    ifu_ppn = '0;
    lsu_ppn = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      ifu_match[i] = entry_valid[i] && (entry_vpn[i] == ifu_vpn);
      lsu_match[i] = entry_valid[i] && (entry_vpn[i] == lsu_vpn);
      ifu_ppn      = ifu_ppn | (entry_ppn[i] & {20{ifu_match[i]}});
      lsu_ppn      = lsu_ppn | (entry_ppn[i] & {20{lsu_match[i]}});
    end
  end

  assign ifu_hit   = !mode_on || (|ifu_match);  // Bare mode always hits
  assign lsu_hit   = !mode_on || (|lsu_match);
  assign ifu_paddr = mode_on ? {ifu_ppn, ifu_off} : ifu_vaddr;
  assign lsu_paddr = mode_on ? {lsu_ppn, lsu_off} : lsu_vaddr;
  assign ifu_miss  = ifu_valid && mode_on && !(|ifu_match);
  assign lsu_miss  = lsu_valid && mode_on && !(|lsu_match);

  // Highest free slot first, else round robin
  always_comb begin
    victim = victim_cnt;
    for (int i = 0; i < ENTRIES; i++) begin
      if (!entry_valid[i]) begin
        victim = `MMU_TLB_INDEX_W'(i);
      end
    end
  end

  // Requester holds its address for the whole walk
  assign fill_vpn = (fill_requester == REQ_LSU) ? lsu_vpn : ifu_vpn;

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      victim_cnt  <= '0;
    end else begin
      victim_cnt <= victim_cnt + 1'b1;
      if (flush) begin
        entry_valid <= '0;  // Flush beats a same-cycle fill
      end else if (fill_valid) begin
        entry_valid[victim] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_valid) begin
      entry_vpn[victim] <= fill_vpn;
      entry_ppn[victim] <= fill_ppn;
    end
  end

  always_comb begin
    dup_vpn = 1'b0;
    for (int i = 0; i < ENTRIES; i++) begin
      for (int j = i + 1; j < ENTRIES; j++) begin
        if (entry_valid[i] && entry_valid[j] && (entry_vpn[i] == entry_vpn[j])) begin
          dup_vpn = 1'b1;
        end
      end
    end
  end

  // Walker only starts on a miss, which needs Sv32 on
  a_fill_needs_sv32: assert property (
    @(posedge clock) disable iff (reset) fill_valid |-> mode_on
  );

  // A page filled twice would mean a walk started for a page already held
  a_no_dup_vpn: assert property (
    @(posedge clock) disable iff (reset) !dup_vpn
  );

endmodule

// File: verilog/sv32_walker.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

module sv32_walker (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            satp,
  input  logic [31:0]            ifu_vaddr,
  input  logic [31:0]            lsu_vaddr,
  input  logic                   ifu_miss,
  input  logic                   lsu_miss,
  input  logic                   arready,
  input  logic                   rvalid,
  input  axi_lite_pkg::axi_data_t rdata,
  input  axi_lite_pkg::axi_resp_t rresp,  // Not checked, PTE reads assumed OKAY
  output logic                   arvalid,
  output axi_lite_pkg::axi_addr_t araddr,
  output axi_lite_pkg::axi_prot_t arprot,
  output logic                   rready,
  output logic                   fill_valid,
  output sv32_pkg::requester_t   fill_requester,
  output sv32_pkg::ppn_t         fill_ppn
);
  import sv32_pkg::*;
  import axi_lite_pkg::*;

  walk_state_t state;
  walk_state_t state_next;
  requester_t  requester;
  requester_t  requester_next;
  logic        level;  // High while reading the first-level PTE
  logic        level_next;
  axi_addr_t   addr_q;
  axi_addr_t   addr_next;
  logic        walk_start;
  ppn_t        root_ppn;
  vpn_t        ifu_vpn;
  vpn_t        lsu_vpn;
  vpn_t        start_vpn;
  vpn_t        walk_vpn;

  assign root_ppn   = satp[19:0];
  assign ifu_vpn    = ifu_vaddr[31:12];
  assign lsu_vpn    = lsu_vaddr[31:12];
  assign walk_start = satp[`MMU_SATP_MODE_BIT] && (ifu_miss || lsu_miss);
  assign start_vpn  = lsu_miss ? lsu_vpn : ifu_vpn;  // LSU has priority
  assign walk_vpn   = (requester == REQ_LSU) ? lsu_vpn : ifu_vpn;

  always_comb begin
    state_next     = state;
    requester_next = requester;
    level_next     = level;
    addr_next      = addr_q;
    case (state)
      WALK_IDLE: begin
        if (walk_start) begin
          state_next     = WALK_AR;
          requester_next = lsu_miss ? REQ_LSU : REQ_IFU;
          level_next     = 1'b1;
          addr_next      = {root_ppn, start_vpn[19:10], 2'b00};
        end
      end
      WALK_AR: begin
        if (arready) begin
          state_next = WALK_R;
        end
      end
      WALK_R: begin
        if (rvalid) begin
          if (level) begin
            // First-level PTE always taken as a pointer
            state_next = WALK_AR;
            level_next = 1'b0;
            addr_next  = {rdata[29:10], walk_vpn[9:0], 2'b00};
          end else begin
            state_next = WALK_IDLE;
          end
        end
      end
      default: begin
        state_next = WALK_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= WALK_IDLE;
      requester <= REQ_IFU;
      level     <= 1'b0;
    end else begin
      state     <= state_next;
      requester <= requester_next;
      level     <= level_next;
    end
  end

  always_ff @(posedge clock) begin
    addr_q <= addr_next;
  end

  assign arvalid = (state == WALK_AR);
  assign araddr  = addr_q;
  assign arprot  = `MMU_ARPROT;
  assign rready  = (state == WALK_R);

  // Leaf beat fills the TLB directly
  assign fill_valid     = (state == WALK_R) && rvalid && !level;
  assign fill_requester = requester;
  assign fill_ppn       = rdata[29:10];

  a_ar_stable: assert property (
    @(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr)
  );

  // R phase only opens after an accepted read address
  a_r_after_ar: assert property (
    @(posedge clock) disable iff (reset) $rose(rready) |-> $past(arvalid && arready)
  );

endmodule

// File: verilog/sv32_mmu.sv
`timescale 1ns/10ps

module sv32_mmu (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    flush,
  input  logic [31:0]             satp,
  input  logic                    ifu_valid,
  input  logic [31:0]             ifu_vaddr,
  output logic                    ifu_hit,
  output logic [31:0]             ifu_paddr,
  input  logic                    lsu_valid,
  input  logic [31:0]             lsu_vaddr,
  output logic                    lsu_hit,
  output logic [31:0]             lsu_paddr,
  output logic                    arvalid,
  input  logic                    arready,
  output axi_lite_pkg::axi_addr_t araddr,
  output axi_lite_pkg::axi_prot_t arprot,
  input  logic                    rvalid,
  output logic                    rready,
  input  axi_lite_pkg::axi_data_t rdata,
  input  axi_lite_pkg::axi_resp_t rresp
);
  import sv32_pkg::*;

  logic       ifu_miss;
  logic       lsu_miss;
  logic       fill_valid;
  requester_t fill_requester;
  ppn_t       fill_ppn;

  sv32_tlb u_tlb (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .satp           (satp),
    .ifu_valid      (ifu_valid),
    .ifu_vaddr      (ifu_vaddr),
    .lsu_valid      (lsu_valid),
    .lsu_vaddr      (lsu_vaddr),
    .fill_valid     (fill_valid),
    .fill_requester (fill_requester),
    .fill_ppn       (fill_ppn),
    .ifu_hit        (ifu_hit),
    .ifu_paddr      (ifu_paddr),
    .lsu_hit        (lsu_hit),
    .lsu_paddr      (lsu_paddr),
    .ifu_miss       (ifu_miss),
    .lsu_miss       (lsu_miss)
  );

  sv32_walker u_walker (
    .clock          (clock),
    .reset          (reset),
    .satp           (satp),
    .ifu_vaddr      (ifu_vaddr),
    .lsu_vaddr      (lsu_vaddr),
    .ifu_miss       (ifu_miss),
    .lsu_miss       (lsu_miss),
    .arready        (arready),
    .rvalid         (rvalid),
    .rdata          (rdata),
    .rresp          (rresp),
    .arvalid        (arvalid),
    .araddr         (araddr),
    .arprot         (arprot),
    .rready         (rready),
    .fill_valid     (fill_valid),
    .fill_requester (fill_requester),
    .fill_ppn       (fill_ppn)
  );

endmodule

// File: dv/pt_memory.sv
`timescale 1ns/10ps

module pt_memory (
  input  logic                    clock,
  input  logic                    reset,
  input  sv32_pkg::ppn_t          root_ppn,
  input  logic                    arvalid,
  output logic                    arready,
  input  axi_lite_pkg::axi_addr_t araddr,
  output logic                    rvalid,
  input  logic                    rready,
  output axi_lite_pkg::axi_data_t rdata,
  output axi_lite_pkg::axi_resp_t rresp
);
  import sv32_pkg::*;
  import axi_lite_pkg::*;

  logic      ready_q = 1'b0;
  logic      valid_q = 1'b0;
  axi_data_t data_q  = '0;
  axi_data_t pte_q   = '0;
  logic      pending = 1'b0;  // AR taken, R beat still owed
  logic      r_beat  = 1'b0;  // R beat taken at the last rising edge
  int        ar_wait = 0;
  int        r_wait  = 0;

  assign arready = ready_q;
  assign rvalid  = valid_q;
  assign rdata   = data_q;
  assign rresp   = RESP_OKAY;

  // First level lives in the root page, leaf tables at page 0x100 + vpn1
  function automatic axi_data_t pte_for(input axi_addr_t addr);
    vpn_t vpn;
    ppn_t ppn;
    if (addr[31:12] == root_ppn) begin
      ppn = 20'h00100 + 20'(addr[11:2]);
    end else begin
      vpn = {10'(addr[31:12] - 20'h00100), addr[11:2]};
      ppn = vpn ^ 20'h05a5a;
    end
    return {2'b00, ppn, 10'h001};  // V bit set
  endfunction

  always @(posedge clock) begin
    r_beat <= rvalid && rready;
  end

  // Beats complete on the rising edge, the model moves on the falling one
  always @(negedge clock) begin
    if (reset) begin
      ready_q = 1'b0;
      valid_q = 1'b0;
      pending = 1'b0;
      ar_wait = int'($urandom % 4);
    end else if (ready_q) begin
      ready_q = 1'b0;  // AR beat done
      pending = 1'b1;
      r_wait  = int'($urandom % 4);
    end else if (valid_q) begin
      if (r_beat) begin
        valid_q = 1'b0;  // Held until rready takes the beat
        pending = 1'b0;
        ar_wait = int'($urandom % 4);
      end
    end else if (pending) begin
      if (r_wait == 0) begin
        valid_q = 1'b1;
        data_q  = pte_q;
      end else begin
        r_wait--;
      end
    end else if (arvalid) begin
      if (ar_wait == 0) begin
        ready_q = 1'b1;
        pte_q   = pte_for(araddr);
      end else begin
        ar_wait--;
      end
    end
  end

endmodule

// File: dv/mmu_checker.sv
`timescale 1ns/10ps
`include "mmu_defines.svh"

module mmu_checker (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [31:0]             satp,
  input  logic                    ifu_valid,
  input  logic [31:0]             ifu_vaddr,
  input  logic                    ifu_hit,
  input  logic [31:0]             ifu_paddr,
  input  logic                    lsu_valid,
  input  logic [31:0]             lsu_vaddr,
  input  logic                    lsu_hit,
  input  logic [31:0]             lsu_paddr,
  input  logic                    arvalid,
  input  logic                    arready,
  input  axi_lite_pkg::axi_addr_t araddr,
  input  axi_lite_pkg::axi_prot_t arprot,
  input  logic                    test_done,
  input  int                      test_id,
  input  int                      exp_ifu_reads,
  input  int                      exp_lsu_reads,
  output int                      error_count,
  output int                      tests_run
);
  import sv32_pkg::*;
  import axi_lite_pkg::*;

  localparam int TLB_ENTRIES = 1 << `MMU_TLB_INDEX_W;
  localparam int ZERO_OR_TWO = -1;  // Page may have been evicted

  int ifu_reads;
  int lsu_reads;
  int test_errors;
  int tests_failed;
  int total_reads;

  function automatic logic [31:0] expected_paddr(input logic [31:0] vaddr);
    vpn_t vpn;
    vpn = vaddr[31:12];
    if (!satp[31]) begin
      return vaddr;  // Bare mode
    end
    return {vpn ^ 20'h05a5a, vaddr[11:0]};
  endfunction

  function automatic logic count_ok(input int seen, input int expected);
    if (expected == ZERO_OR_TWO) begin
      return (seen == 0) || (seen == 2);
    end
    return seen == expected;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic check_paddr(input string port, input logic [31:0] vaddr,
                             input logic [31:0] paddr);
    logic [31:0] expected;
    expected = expected_paddr(vaddr);
    if (paddr !== expected) begin
      report_error($sformatf("test %0d %s vaddr %h gave paddr %h, expected %h",
                             test_id, port, vaddr, paddr, expected));
    end
  endtask

  // LSU walks first when both ports miss
  task automatic check_read();
    logic      use_lsu;
    vpn_t      vpn;
    int        seen;
    axi_addr_t expected;
    use_lsu = lsu_valid && (exp_lsu_reads != 0) && (lsu_reads < 2);
    vpn     = use_lsu ? lsu_vaddr[31:12] : ifu_vaddr[31:12];
    seen    = use_lsu ? lsu_reads : ifu_reads;
    if (seen % 2 == 0) begin
      expected = {satp[19:0], vpn[19:10], 2'b00};
    end else begin
      expected = {20'h00100 + 20'(vpn[19:10]), vpn[9:0], 2'b00};
    end
    if (araddr !== expected) begin
      report_error($sformatf("test %0d read %0d at araddr %h, expected %h",
                             test_id, ifu_reads + lsu_reads, araddr, expected));
    end
    if (arprot !== `MMU_ARPROT) begin
      report_error($sformatf("test %0d read with arprot %b, expected %b",
                             test_id, arprot, `MMU_ARPROT));
    end
    if (use_lsu) begin
      lsu_reads++;
    end else begin
      ifu_reads++;
    end
  endtask

  task automatic finish_test();
    if (!count_ok(ifu_reads, exp_ifu_reads) || !count_ok(lsu_reads, exp_lsu_reads)) begin
      report_error($sformatf("test %0d made %0d IFU and %0d LSU reads, expected %0d and %0d",
                             test_id, ifu_reads, lsu_reads, exp_ifu_reads, exp_lsu_reads));
    end
    if (test_errors == 0) begin
      $display("test %0d passed, %0d reads", test_id, ifu_reads + lsu_reads);
    end else begin
      $display("test %0d failed with %0d errors", test_id, test_errors);
      tests_failed++;
    end
    tests_run++;
    total_reads += ifu_reads + lsu_reads;
    ifu_reads   = 0;
    lsu_reads   = 0;
    test_errors = 0;
  endtask

  task automatic print_counts();
    $display("Counts: %0d tests run, %0d failed, %0d errors, %0d reads, %0d-entry TLB",
             tests_run, tests_failed, error_count, total_reads, TLB_ENTRIES);
  endtask

  always @(posedge clock) begin
    if (reset) begin
      error_count  = 0;
      tests_run    = 0;
      tests_failed = 0;
      total_reads  = 0;
      ifu_reads    = 0;
      lsu_reads    = 0;
      test_errors  = 0;
    end else begin
      if (ifu_valid && ifu_hit) begin
        check_paddr("IFU", ifu_vaddr, ifu_paddr);
      end
      if (lsu_valid && lsu_hit) begin
        check_paddr("LSU", lsu_vaddr, lsu_paddr);
      end
      if (arvalid && arready) begin
        check_read();
      end
      if (test_done) begin
        finish_test();
      end
    end
  end

endmodule

// File: dv/tb_sv32_mmu.sv
`timescale 1ns/10ps

module tb_sv32_mmu;
  import sv32_pkg::*;
  import axi_lite_pkg::*;

  localparam int          NUM_TESTS      = 47;
  localparam int          PAGES          = 20;
  localparam int          TIMEOUT_CYCLES = NUM_TESTS * 40;
  localparam int          ZERO_OR_TWO    = -1;
  localparam logic [31:0] SATP_ON        = 32'h8000_0080;  // Root table at page 0x80
  localparam logic [31:0] SATP_OFF       = 32'h0000_0080;

  typedef struct packed {
    logic [31:0] satp;
    logic        flush;
    logic        ifu_valid;
    logic [31:0] ifu_vaddr;
    int          ifu_reads;
    logic        lsu_valid;
    logic [31:0] lsu_vaddr;
    int          lsu_reads;
  } stim_t;

  logic        clock = 1'b0;
  logic        reset;
  logic        flush;
  logic [31:0] satp;
  logic        ifu_valid;
  logic [31:0] ifu_vaddr;
  logic        ifu_hit;
  logic [31:0] ifu_paddr;
  logic        lsu_valid;
  logic [31:0] lsu_vaddr;
  logic        lsu_hit;
  logic [31:0] lsu_paddr;
  logic        arvalid;
  logic        arready;
  axi_addr_t   araddr;
  axi_prot_t   arprot;
  logic        rvalid;
  logic        rready;
  axi_data_t   rdata;
  axi_resp_t   rresp;
  logic        test_done;
  int          test_id;
  int          exp_ifu_reads;
  int          exp_lsu_reads;
  int          error_count;
  int          tests_run;
  stim_t       stim [NUM_TESTS];
  int          n_stim = 0;
  int          cycle_count = 0;

  sv32_mmu i_dut (.*);

  pt_memory u_mem (.root_ppn(satp[19:0]), .*);

  mmu_checker u_chk (.*);

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic add_test(input logic [31:0] satp_v, input logic flush_v,
                          input logic ifu_v, input logic [31:0] ifu_a, input int ifu_r,
                          input logic lsu_v, input logic [31:0] lsu_a, input int lsu_r);
    stim[n_stim] = {satp_v, flush_v, ifu_v, ifu_a, ifu_r, lsu_v, lsu_a, lsu_r};
    n_stim++;
  endtask

  task automatic build_table();
    logic [19:0] vpn;
    logic [31:0] addr;
    int          reads;
    // satp, flush, IFU valid/vaddr/reads, LSU valid/vaddr/reads
    add_test(SATP_OFF, 1'b0, 1'b1, 32'h1234_5678, 0, 1'b1, 32'hdead_beef, 0);
    add_test(SATP_ON,  1'b0, 1'b1, 32'h0040_1abc, 2, 1'b0, 32'h0,         0);
    add_test(SATP_ON,  1'b0, 1'b1, 32'h0040_1004, 0, 1'b1, 32'h0040_1ffc, 0);
    add_test(SATP_ON,  1'b0, 1'b1, 32'h1230_0010, 2, 1'b1, 32'h7ff0_2020, 2);
    add_test(SATP_ON,  1'b0, 1'b1, 32'h7ff0_2444, 0, 1'b1, 32'h1230_0888, 0);
    add_test(SATP_ON,  1'b1, 1'b0, 32'h0,         0, 1'b1, 32'h0040_1234, 2);
    add_test(SATP_ON,  1'b0, 1'b1, 32'h0040_1800, 0, 1'b0, 32'h0,         0);
    // Twenty pages, then each again through the other port
    for (int i = 0; i < 2 * PAGES; i++) begin
      vpn   = 20'h20000 + 20'(i % PAGES) * 20'h00457;
      addr  = {vpn, 12'(i * 164)};
      reads = (i < PAGES) ? 2 : ZERO_OR_TWO;
      if ((i % 2 == 0) == (i < PAGES)) begin
        add_test(SATP_ON, 1'b0, 1'b1, addr, reads, 1'b0, 32'h0, 0);
      end else begin
        add_test(SATP_ON, 1'b0, 1'b0, 32'h0, 0, 1'b1, addr, reads);
      end
    end
  endtask

  task automatic run_test(input int t);
    @(negedge clock);
    test_done = 1'b0;
    if (stim[t].flush) begin
      flush     = 1'b1;
      ifu_valid = 1'b0;
      lsu_valid = 1'b0;
      @(negedge clock);
      flush = 1'b0;
    end
    satp          = stim[t].satp;
    ifu_valid     = stim[t].ifu_valid;
    ifu_vaddr     = stim[t].ifu_vaddr;
    lsu_valid     = stim[t].lsu_valid;
    lsu_vaddr     = stim[t].lsu_vaddr;
    test_id       = t;
    exp_ifu_reads = stim[t].ifu_reads;
    exp_lsu_reads = stim[t].lsu_reads;
    do begin
      @(negedge clock);
    end while ((ifu_valid && !ifu_hit) || (lsu_valid && !lsu_hit));
    test_done = 1'b1;  // Checker closes the test at the next rising edge
  endtask

  initial begin
    void'($urandom(32'h566d_03b4));
    reset         = 1'b1;
    flush         = 1'b0;
    satp          = SATP_OFF;
    ifu_valid     = 1'b0;
    ifu_vaddr     = '0;
    lsu_valid     = 1'b0;
    lsu_vaddr     = '0;
    test_done     = 1'b0;
    test_id       = 0;
    exp_ifu_reads = 0;
    exp_lsu_reads = 0;
    build_table();
    repeat (4) @(negedge clock);
    reset = 1'b0;
    for (int t = 0; t < n_stim; t++) begin
      run_test(t);
    end
    @(negedge clock);
    test_done = 1'b0;
    repeat (2) @(negedge clock);
    u_chk.print_counts();
    if (tests_run != NUM_TESTS) begin
      $display("Only %0d of %0d tests were closed by the checker", tests_run, NUM_TESTS);
    end
    if (error_count == 0 && tests_run == NUM_TESTS) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verilog
verilog/sv32_pkg.sv
verilog/axi_lite_pkg.sv
verilog/sv32_tlb.sv
verilog/sv32_walker.sv
verilog/sv32_mmu.sv
dv/pt_memory.sv
dv/mmu_checker.sv
dv/tb_sv32_mmu.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the Sv32 MMU testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sv32_mmu -f verilog.f \
  && (obj_dir/Vtb_sv32_mmu > sim.log 2>&1 || echo "FAIL: see errors above" >> sim.log) \
  || { echo "Verilator build failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
